/* hdl/cclut_pkg.sv */
package cclut_pkg;

  // ----------------------------------------
  // field widths and chamber geometry
  // ----------------------------------------
  localparam int mx_hs_w     = 8;
  // half-strips per chamber
  localparam int mx_hs_count = 224;
  localparam int mx_pid_w    = 4;
  // comparator code, also rom address
  localparam int mx_ccode_w  = 12;
  localparam int mx_bend_w   = 5;
  // bend magnitude, sign sits above it
  localparam int mx_mag_w    = 4;
  localparam int mx_offs_w   = 4;
  // lookup word: offset 8..5, bend 4..0
  localparam int mx_dat_w    = mx_offs_w + mx_bend_w;
  localparam int mx_rom_depth = 1 << mx_ccode_w;

  // eighth-strip position
  localparam int mx_es_w = 10;
  localparam int es_max  = 4 * mx_hs_count - 1;

  localparam int n_layers  = 6;
  localparam int n_pids    = 5;
  // offset code meaning no shift
  localparam int offs_zero = 7;

  // ----------------------------------------
  // pattern ids and bend bases
  // ----------------------------------------
  localparam logic [mx_pid_w-1:0] pid_pat0 = 4'd0;
  localparam logic [mx_pid_w-1:0] pid_pat1 = 4'd1;
  localparam logic [mx_pid_w-1:0] pid_pat2 = 4'd2;
  localparam logic [mx_pid_w-1:0] pid_pat3 = 4'd3;
  localparam logic [mx_pid_w-1:0] pid_pat4 = 4'd4;

  localparam int base_straight = 0;
  localparam int base_mid      = 4;
  localparam int base_wide     = 8;
  localparam int bend_mag_max  = 15;

  // fit rule for one rom word, pid and comparator code in
  function automatic logic [mx_dat_w-1:0] cclut_entry(
    input logic [mx_pid_w-1:0]   pid,
    input logic [mx_ccode_w-1:0] ccode
  );
    int c;
    int pos;
    int sum;
    int pos_first;
    int pos_last;
    int base;
    int mag;
    logic sign;
    sum = 0;
    pos_first = 0;
    pos_last = 0;
    for (int l = 0; l < n_layers; l++) begin
      c = int'(ccode[2*l +: 2]);
      // hit layers sit at c-2, missing layers at 0
      pos = (c != 0) ? c - 2 : 0;
      sum += pos;
      if (l == 0) pos_first = pos;
      if (l == n_layers - 1) pos_last = pos;
    end
    case (pid)
      pid_pat4: base = base_straight;
      pid_pat3, pid_pat2: base = base_mid;
      default: base = base_wide;
    endcase
    // lever arm from first to last layer
    mag = base + ((pos_last > pos_first) ? pos_last - pos_first : pos_first - pos_last);
    if (mag > bend_mag_max) mag = bend_mag_max;
    sign = (pid == pid_pat3) || (pid == pid_pat1);
    cclut_entry = {mx_offs_w'(offs_zero + sum), sign, mx_mag_w'(mag)};
  endfunction

endpackage

/* hdl/clct_if.sv */
`timescale 1ns/1ps

interface clct_if
  import cclut_pkg::*;
();

  // one candidate from the pattern finder
  logic                  valid;
  logic [mx_hs_w-1:0]    key_hs;
  logic [mx_pid_w-1:0]   pid;
  logic [mx_ccode_w-1:0] ccode;

  // lookup side only needs pattern and code
  modport lookup (
    input pid,
    input ccode
  );

  // refine side takes strobe and key position
  modport refine (
    input valid,
    input key_hs
  );

endinterface

/* hdl/cclut_rom.sv */
`timescale 1ns/1ps

module cclut_rom
  import cclut_pkg::*;
#(
  parameter int pid = 0
) (
  input  logic                  clock,
  input  logic [mx_ccode_w-1:0] adr0,
  input  logic [mx_ccode_w-1:0] adr1,
  output logic [mx_dat_w-1:0]   rd0,
  output logic [mx_dat_w-1:0]   rd1
);

  // ----------------------------------------
  // rom image
  // ----------------------------------------
  logic [mx_dat_w-1:0] mem [mx_rom_depth];

  // contents from the fit rule, one word per code
  initial begin
    for (int a = 0; a < mx_rom_depth; a++) begin
      mem[a] = cclut_entry(mx_pid_w'(pid), mx_ccode_w'(a));
    end
  end

  // ----------------------------------------
  // read ports
  // ----------------------------------------
  // falling edge read, word settles mid cycle
  // so the rising edge stage can use it
  always_ff @(negedge clock) begin
    rd0 <= mem[adr0];
    rd1 <= mem[adr1];
  end

endmodule

/* hdl/pattern_lut_cclut.sv */
`timescale 1ns/1ps

module pattern_lut_cclut
  import cclut_pkg::*;
(
  input  logic                 clock,
  clct_if.lookup               cand0,
  clct_if.lookup               cand1,
  output logic [mx_bend_w-1:0] bend0,
  output logic [mx_bend_w-1:0] bend1,
  output logic [mx_offs_w-1:0] offs0,
  output logic [mx_offs_w-1:0] offs1,
  output logic                 match0,
  output logic                 match1
);

  // rom words per pattern id, per channel
  logic [n_pids-1:0][mx_dat_w-1:0] rd0_pat;
  logic [n_pids-1:0][mx_dat_w-1:0] rd1_pat;

  // selected word per channel
  logic [mx_dat_w-1:0] rd0;
  logic [mx_dat_w-1:0] rd1;

  // pick one word by pid, match flag on top
  function automatic logic [mx_dat_w:0] pick_word(
    input logic [mx_pid_w-1:0]             pid,
    input logic [n_pids-1:0][mx_dat_w-1:0] words
  );
    case (pid)
      pid_pat4: pick_word = {1'b1, words[pid_pat4]};
      pid_pat3: pick_word = {1'b1, words[pid_pat3]};
      pid_pat2: pick_word = {1'b1, words[pid_pat2]};
      pid_pat1: pick_word = {1'b1, words[pid_pat1]};
      pid_pat0: pick_word = {1'b1, words[pid_pat0]};
      // unknown pattern, blank word
      default: pick_word = '0;
    endcase
  endfunction

  // ----------------------------------------
  // pattern roms, all share both codes
  // ----------------------------------------
  cclut_rom #(.pid(pid_pat0)) rom_pat0 (
    .clock(clock),
    .adr0 (cand0.ccode),
    .adr1 (cand1.ccode),
    .rd0  (rd0_pat[pid_pat0]),
    .rd1  (rd1_pat[pid_pat0])
  );

  cclut_rom #(.pid(pid_pat1)) rom_pat1 (
    .clock(clock),
    .adr0 (cand0.ccode),
    .adr1 (cand1.ccode),
    .rd0  (rd0_pat[pid_pat1]),
    .rd1  (rd1_pat[pid_pat1])
  );

  cclut_rom #(.pid(pid_pat2)) rom_pat2 (
    .clock(clock),
    .adr0 (cand0.ccode),
    .adr1 (cand1.ccode),
    .rd0  (rd0_pat[pid_pat2]),
    .rd1  (rd1_pat[pid_pat2])
  );

  cclut_rom #(.pid(pid_pat3)) rom_pat3 (
    .clock(clock),
    .adr0 (cand0.ccode),
    .adr1 (cand1.ccode),
    .rd0  (rd0_pat[pid_pat3]),
    .rd1  (rd1_pat[pid_pat3])
  );

  cclut_rom #(.pid(pid_pat4)) rom_pat4 (
    .clock(clock),
    .adr0 (cand0.ccode),
    .adr1 (cand1.ccode),
    .rd0  (rd0_pat[pid_pat4]),
    .rd1  (rd1_pat[pid_pat4])
  );

  // ----------------------------------------
  // pid demux, pid held through the cycle
  // ----------------------------------------
  always_comb begin
    {match0, rd0} = pick_word(cand0.pid, rd0_pat);
    {match1, rd1} = pick_word(cand1.pid, rd1_pat);
    // bend low, offset high
    bend0 = rd0[mx_bend_w-1:0];
    bend1 = rd1[mx_bend_w-1:0];
    offs0 = rd0[mx_dat_w-1:mx_bend_w];
    offs1 = rd1[mx_dat_w-1:mx_bend_w];
  end

endmodule

/* hdl/clct_position_refine.sv */
`timescale 1ns/1ps

module clct_position_refine
  import cclut_pkg::*;
(
  input  logic                 clock,
  input  logic                 rst,
  clct_if.refine               cand,
  input  logic [mx_bend_w-1:0] bend,
  input  logic [mx_offs_w-1:0] offs,
  input  logic                 match,
  output logic                 out_valid,
  output logic [mx_hs_w-1:0]   out_key_hs,
  output logic                 out_qs,
  output logic                 out_es
  ,
  output logic [mx_bend_w-1:0] out_bend
);

  // signed eighth-strip sum, two spare bits
  logic signed [mx_es_w+1:0] es_raw;
  // clamped position inside the chamber
  logic [mx_es_w-1:0]        es_pos;

  // ----------------------------------------
  // offset applied at eighth-strip scale
  // ----------------------------------------
  always_comb begin
    // 4*key_hs + offs - 7
    es_raw = $signed({2'b00, cand.key_hs, 2'b00})
           + $signed({{(mx_es_w+2-mx_offs_w){1'b0}}, offs})
           - $signed((mx_es_w+2)'(offs_zero));
    // clamp at both chamber edges
    if (es_raw < 0) begin
      es_pos = '0;
    end else if (es_raw > es_max) begin
      es_pos = mx_es_w'(es_max);
    end else begin
      es_pos = es_raw[mx_es_w-1:0];
    end
  end

  // ----------------------------------------
  // output register
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (rst) begin
      out_valid  <= 1'b0;
      out_key_hs <= '0;
      out_qs     <= 1'b0;
      out_es     <= 1'b0;
      out_bend   <= '0;
    end else begin
      // unknown pattern ids drop the candidate
      out_valid  <= cand.valid & match;
      out_key_hs <= es_pos[mx_es_w-1:2];
      out_qs     <= es_pos[1];
      out_es     <= es_pos[0];
      out_bend   <= bend;
    end
  end

endmodule

/* hdl/cclut_top.sv */
`timescale 1ns/1ps

module cclut_top
  import cclut_pkg::*;
(
  input  logic                  clock,
  input  logic                  rst,
  // first candidate
  input  logic                  clct0_valid,
  input  logic [mx_hs_w-1:0]    clct0_key_hs,
  input  logic [mx_pid_w-1:0]   clct0_pid,
  input  logic [mx_ccode_w-1:0] clct0_ccode,
  // second candidate
  input  logic                  clct1_valid,
  input  logic [mx_hs_w-1:0]    clct1_key_hs,
  input  logic [mx_pid_w-1:0]   clct1_pid,
  input  logic [mx_ccode_w-1:0] clct1_ccode,
  // refined first candidate
  output logic                  out0_valid,
  output logic [mx_hs_w-1:0]    out0_key_hs,
  output logic                  out0_qs,
  output logic                  out0_es,
  output logic [mx_bend_w-1:0]  out0_bend,
  // refined second candidate
  output logic                  out1_valid,
  output logic [mx_hs_w-1:0]    out1_key_hs,
  output logic                  out1_qs,
  output logic                  out1_es,
  output logic [mx_bend_w-1:0]  out1_bend
);

  // lookup results per channel
  logic [mx_bend_w-1:0] bend0;
  logic [mx_bend_w-1:0] bend1;
  logic [mx_offs_w-1:0] offs0;
  logic [mx_offs_w-1:0] offs1;
  logic                 match0;
  logic                 match1;

  // ----------------------------------------
  // candidate bundles
  // ----------------------------------------
  clct_if cand0 ();
  clct_if cand1 ();

  assign cand0.valid  = clct0_valid;
  assign cand0.key_hs = clct0_key_hs;
  assign cand0.pid    = clct0_pid;
  assign cand0.ccode  = clct0_ccode;

  assign cand1.valid  = clct1_valid;
  assign cand1.key_hs = clct1_key_hs;
  assign cand1.pid    = clct1_pid;
  assign cand1.ccode  = clct1_ccode;

  // ----------------------------------------
  // lookup, then per-channel refine
  // ----------------------------------------
  pattern_lut_cclut lut (
    .clock (clock),
    .cand0 (cand0.lookup),
    .cand1 (cand1.lookup),
    .bend0 (bend0),
    .bend1 (bend1),
    .offs0 (offs0),
    .offs1 (offs1),
    .match0(match0),
    .match1(match1)
  );

  clct_position_refine refine0 (
    .clock     (clock),
    .rst       (rst),
    .cand      (cand0.refine),
    .bend      (bend0),
    .offs      (offs0),
    .match     (match0),
    .out_valid (out0_valid),
    .out_key_hs(out0_key_hs),
    .out_qs    (out0_qs),
    .out_es    (out0_es),
    .out_bend  (out0_bend)
  );

  clct_position_refine refine1 (
    .clock     (clock),
    .rst       (rst),
    .cand      (cand1.refine),
    .bend      (bend1),
    .offs      (offs1),
    .match     (match1),
    .out_valid (out1_valid),
    .out_key_hs(out1_key_hs),
    .out_qs    (out1_qs),
    .out_es    (out1_es),
    .out_bend  (out1_bend)
  );

endmodule

/* verif/tb_cclut_top.sv */
`timescale 1ns/1ps

module tb_cclut_top
  import cclut_pkg::*;
();

  // ----------------------------------------
  // run length and watchdog budget
  // ----------------------------------------
  localparam int n_random    = 2000;
  localparam int n_invalid   = 27;
  localparam int n_edge      = 8;
  localparam int n_indep     = 20;
  localparam int n_vectors   = n_random + n_invalid + n_edge + n_indep;
  localparam int clk_period  = 8;
  localparam int n_reset     = 10;
  // one spare cycle for the post-reset check
  localparam int watchdog_ns = (n_vectors + n_reset + 1) * clk_period + 200;

  logic                  clock;
  logic                  rst;
  logic                  clct0_valid;
  logic [mx_hs_w-1:0]    clct0_key_hs;
  logic [mx_pid_w-1:0]   clct0_pid;
  logic [mx_ccode_w-1:0] clct0_ccode;
  logic                  clct1_valid;
  logic [mx_hs_w-1:0]    clct1_key_hs;
  logic [mx_pid_w-1:0]   clct1_pid;
  logic [mx_ccode_w-1:0] clct1_ccode;
  logic                  out0_valid;
  logic [mx_hs_w-1:0]    out0_key_hs;
  logic                  out0_qs;
  logic                  out0_es;
  logic [mx_bend_w-1:0]  out0_bend;
  logic                  out1_valid;
  logic [mx_hs_w-1:0]    out1_key_hs;
  logic                  out1_qs;
  logic                  out1_es;
  logic [mx_bend_w-1:0]  out1_bend;

  integer seed = 23558;
  int errors = 0;
  int checks = 0;

  // expected per channel: valid, key_hs[7:0], qs, es, bend[4:0]
  logic [15:0] exp0_q [$];
  logic [15:0] exp1_q [$];

  cclut_top UUT (.*);

  // 8 ns clock
  initial clock = 1'b0;
  always #4 clock = ~clock;

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  // lookup word from the layer fit, offset above bend
  function automatic logic [8:0] fit_word(input logic [3:0] pid, input logic [11:0] ccode);
    int code;
    int hit_pos [6];
    int sum;
    int span;
    int mag;
    logic sign;
    sum = 0;
    for (int l = 0; l < 6; l++) begin
      code = int'(ccode[2*l +: 2]);
      // empty layer sits at zero
      hit_pos[l] = (code == 0) ? 0 : code - 2;
      sum = sum + hit_pos[l];
    end
    span = hit_pos[5] - hit_pos[0];
    if (span < 0) span = -span;
    if (pid == 4) mag = span;
    else if (pid == 3 || pid == 2) mag = 4 + span;
    else mag = 8 + span;
    if (mag > 15) mag = 15;
    sign = (pid == 3) || (pid == 1);
    fit_word = {4'(7 + sum), sign, 4'(mag)};
  endfunction

  // refined outputs for one candidate
  function automatic logic [15:0] model_out(input logic valid, input logic [7:0] key_hs,
                                            input logic [3:0] pid, input logic [11:0] ccode);
    logic [8:0] word;
    logic       known;
    int         pos;
    known = (pid <= 4);
    // unknown pid reads a blank word
    word = known ? fit_word(pid, ccode) : 9'd0;
    pos = 4 * int'(key_hs) + int'(word[8:5]) - 7;
    if (pos < 0) pos = 0;
    if (pos > 895) pos = 895;
    model_out = {valid & known, 8'(pos / 4), pos[1], pos[0], word[4:0]};
  endfunction

  // ----------------------------------------
  // checks
  // ----------------------------------------
  task automatic compare_channel(input int ch, input logic [15:0] exp, input logic v,
                                 input logic [7:0] k, input logic qs, input logic es,
                                 input logic [4:0] bend);
    checks++;
    if (v !== exp[15]) begin
      errors++;
      $display("[FAIL] %0t ch%0d out_valid got %b expected %b", $time, ch, v, exp[15]);
    end
    if (k !== exp[14:7]) begin
      errors++;
      $display("[FAIL] %0t ch%0d out_key_hs got %0d expected %0d", $time, ch, k, exp[14:7]);
    end
    if (qs !== exp[6]) begin
      errors++;
      $display("[FAIL] %0t ch%0d out_qs got %b expected %b", $time, ch, qs, exp[6]);
    end
    if (es !== exp[5]) begin
      errors++;
      $display("[FAIL] %0t ch%0d out_es got %b expected %b", $time, ch, es, exp[5]);
    end
    if (bend !== exp[4:0]) begin
      errors++;
      $display("[FAIL] %0t ch%0d out_bend got %h expected %h", $time, ch, bend, exp[4:0]);
    end
  endtask

  // all outputs cleared while in reset
  task automatic check_reset_outputs();
    compare_channel(0, 16'd0, out0_valid, out0_key_hs, out0_qs, out0_es, out0_bend);
    compare_channel(1, 16'd0, out1_valid, out1_key_hs, out1_qs, out1_es, out1_bend);
  endtask

  // drive one pair, then check it one rising edge later
  task automatic apply_pair(input logic v0, input logic [7:0] k0, input logic [3:0] p0,
                            input logic [11:0] c0, input logic v1, input logic [7:0] k1,
                            input logic [3:0] p1, input logic [11:0] c1);
    logic [15:0] exp0;
    logic [15:0] exp1;
    clct0_valid  = v0;
    clct0_key_hs = k0;
    clct0_pid    = p0;
    clct0_ccode  = c0;
    clct1_valid  = v1;
    clct1_key_hs = k1;
    clct1_pid    = p1;
    clct1_ccode  = c1;
    exp0_q.push_back(model_out(v0, k0, p0, c0));
    exp1_q.push_back(model_out(v1, k1, p1, c1));
    @(posedge clock);
    #1;
    exp0 = exp0_q.pop_front();
    exp1 = exp1_q.pop_front();
    compare_channel(0, exp0, out0_valid, out0_key_hs, out0_qs, out0_es, out0_bend);
    compare_channel(1, exp1, out1_valid, out1_key_hs, out1_qs, out1_es, out1_bend);
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin
    logic        v0;
    logic        v1;
    logic [7:0]  k0;
    logic [7:0]  k1;
    logic [3:0]  p0;
    logic [3:0]  p1;
    logic [11:0] c0;
    logic [11:0] c1;
    rst = 1'b1;
    apply_idle();
    repeat (n_reset) begin
      @(posedge clock);
      #1;
      check_reset_outputs();
    end
    rst = 1'b0;
    // first cycle out of reset, idle inputs registered
    @(posedge clock);
    #1;
    if (out0_valid !== 1'b0 || out1_valid !== 1'b0) begin
      errors++;
      $display("[FAIL] %0t out_valid high in first cycle after reset", $time);
    end

    // random pids 0..4, mostly valid
    for (int i = 0; i < n_random; i++) begin
      v0 = ($unsigned($random(seed)) % 8) != 0;
      v1 = ($unsigned($random(seed)) % 8) != 0;
      k0 = 8'($unsigned($random(seed)) % 224);
      k1 = 8'($unsigned($random(seed)) % 224);
      p0 = 4'($unsigned($random(seed)) % 5);
      p1 = 4'($unsigned($random(seed)) % 5);
      c0 = 12'($random(seed));
      c1 = 12'($random(seed));
      apply_pair(v0, k0, p0, c0, v1, k1, p1, c1);
    end

    // unknown pids with valid high
    for (int p = 5; p < 16; p++) begin
      k0 = 8'($unsigned($random(seed)) % 224);
      k1 = 8'($unsigned($random(seed)) % 224);
      apply_pair(1'b1, k0, 4'(p), 12'($random(seed)), 1'b1, k1, 4'(p), 12'($random(seed)));
    end
    // valid low over every pid
    for (int p = 0; p < 16; p++) begin
      k0 = 8'($unsigned($random(seed)) % 224);
      k1 = 8'($unsigned($random(seed)) % 224);
      apply_pair(1'b0, k0, 4'(p), 12'($random(seed)), 1'b0, k1, 4'(15 - p),
                 12'($random(seed)));
    end

    // chamber edges, 0x555 gives offset 1, 0xfff gives 13
    for (int ki = 0; ki < 4; ki++) begin
      for (int ci = 0; ci < 2; ci++) begin
        k0 = (ki < 2) ? 8'(ki) : 8'(220 + ki);
        c0 = (ci == 0) ? 12'h555 : 12'hfff;
        c1 = (ci == 0) ? 12'hfff : 12'h555;
        apply_pair(1'b1, k0, 4'd4, c0, 1'b1, k0, 4'd0, c1);
      end
    end

    // channels differ, one side sometimes dropped
    for (int i = 0; i < n_indep; i++) begin
      v0 = (i % 4) != 1;
      v1 = (i % 4) != 3;
      p0 = 4'(i % 5);
      p1 = (i % 7 == 6) ? 4'd9 : 4'(4 - (i % 5));
      k0 = 8'($unsigned($random(seed)) % 224);
      k1 = 8'($unsigned($random(seed)) % 224);
      apply_pair(v0, k0, p0, 12'($random(seed)), v1, k1, p1, 12'($random(seed)));
    end

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // idle values on every candidate input
  task automatic apply_idle();
    clct0_valid  = 1'b0;
    clct0_key_hs = '0;
    clct0_pid    = '0;
    clct0_ccode  = '0;
    clct1_valid  = 1'b0;
    clct1_key_hs = '0;
    clct1_pid    = '0;
    clct1_ccode  = '0;
  endtask

  // ----------------------------------------
  // watchdog
  // ----------------------------------------
  initial begin
    #(watchdog_ns);
    $display("timeout: stimulus still running after %0d ns", watchdog_ns);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* cclut_top.f */
hdl/cclut_pkg.sv
hdl/clct_if.sv
hdl/cclut_rom.sv
hdl/pattern_lut_cclut.sv
hdl/clct_position_refine.sv
hdl/cclut_top.sv
verif/tb_cclut_top.sv

/* Makefile */
# verilator build and run for the cclut testbench

TOP := tb_cclut_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) \
	  -f cclut_top.f --Mdir obj_dir -o V$(TOP)

# a simulator crash also counts as failure
run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "TB FAILED" >> sim.log
	cat sim.log
	@if grep -q "TB FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
